// File: common/secded_pkg.sv
// SECDED package with codeword geometry and the outcome enum, shared by the RTL and the testbench
package secded_pkg;

    // ------------------------------------------------------------------------
    // Decode outcome
    // ------------------------------------------------------------------------

    // Error class reported with every decoded word
    // One code per decode outcome
    typedef enum logic [1:0] {
        ERR_NONE             = 2'd0,
        ERR_SINGLE_CORRECTED = 2'd1,
        ERR_OVERALL_BIT      = 2'd2,
        ERR_DOUBLE           = 2'd3
    } err_class_e;

    // ------------------------------------------------------------------------
    // Codeword geometry
    // ------------------------------------------------------------------------

    // Number of Hamming check bits for a data width
    // Smallest p such that 2^p covers data, check bits and the zero syndrome
    function automatic int parity_bits(input int width);
        int p;
        p = 1;
        // Grow p until every position plus "no error" has its own code
        while ((2 ** p) < (width + p + 1)) begin
            p = p + 1;
        end
        return p;
    endfunction

    // Full codeword length
    // Data bits, Hamming check bits and one overall parity bit on top
    function automatic int total_width(input int width);
        int p;
        p = parity_bits(width);
        return width + p + 1;
    endfunction

    // Codeword index holding data bit k
    // Positions count from 1 and live at index position - 1
    // Power-of-two positions belong to the check bits and are skipped
    function automatic int data_index(input int width, input int k);
        int pos;
        int seen;
        int limit;
        pos   = 0;
        seen  = -1;
        // Last position below the overall parity bit
        limit = total_width(width) - 1;
        while ((seen < k) && (pos < limit)) begin
            pos = pos + 1;
            // Non power of two means this position carries data
            if ((pos & (pos - 1)) != 0) begin
                seen = seen + 1;
            end
        end
        return pos - 1;
    endfunction

    // Example for width 4
    //   index  7   6   5   4   3   2   1   0
    //   bit    P   D3  D2  D1  C2  D0  C1  C0
    // Here P is the overall parity, Cn the check bit at position 2^n

endpackage : secded_pkg

// File: decoder/secded_syndrome_check.sv
// Combinational SECDED checker that forms the syndrome and parity mismatch for the corrector
`timescale 1ns/10ps

module secded_syndrome_check #(
    // Data width carried by the codeword
    parameter int WIDTH = 16
) (
    // Received codeword with the overall parity bit in the MSB
    input  logic [secded_pkg::total_width(WIDTH)-1:0] codeword,
    // Hamming syndrome that is zero when all check groups agree
    output logic [secded_pkg::parity_bits(WIDTH)-1:0] syndrome,
    // Overall parity disagrees with the stored MSB
    output logic                                       overall_mismatch
);

    // ------------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------------

    // Number of check bits, also the syndrome width
    localparam int SYN_W = secded_pkg::parity_bits(WIDTH);
    // Codeword length including the overall parity bit
    localparam int CW_W  = secded_pkg::total_width(WIDTH);

    // ------------------------------------------------------------------------
    // Coverage masks
    // ------------------------------------------------------------------------

    // Set of codeword indices covered by check bit number check
    // A position is covered when bit check of its position number is set
    // The overall parity bit at the MSB is never part of a Hamming group
    // The check bit's own position is included, so the XOR yields the
    // syndrome bit directly instead of a recomputed parity
    function automatic logic [CW_W-1:0] cover_mask(input int check);
        logic [CW_W-1:0] mask;
        int              j;
        mask = '0;
        for (j = 0; j < CW_W - 1; j++) begin
            // Position number is index plus one
            if ((((j + 1) >> check) & 1) != 0) begin
                mask[j] = 1'b1;
            end
        end
        return mask;
    endfunction

    // ------------------------------------------------------------------------
    // Syndrome trees
    // ------------------------------------------------------------------------

    // One XOR reduction per check bit
    // Masks are constants, so each tree only sees its covered bits
    for (genvar i = 0; i < SYN_W; i++) begin : g_syn
        // Coverage of check bit i, fixed at elaboration
        localparam logic [CW_W-1:0] MASK = cover_mask(i);

        // Odd count of ones in the group flags that group
        assign syndrome[i] = ^(codeword & MASK);
    end

    // Syndrome value read as a number is the failing position
    // e.g. syndrome 5 points at position 5 and so index 4

    // ------------------------------------------------------------------------
    // Overall parity
    // ------------------------------------------------------------------------

    // Parity recomputed over everything below the MSB
    logic lower_parity;

    assign lower_parity = ^codeword[CW_W-2:0];

    // Mismatch means an odd number of flipped bits
    // Match with a non-zero syndrome means an even number, at least two
    assign overall_mismatch = lower_parity ^ codeword[CW_W-1];

endmodule : secded_syndrome_check

// File: decoder/secded_corrector.sv
// SECDED output stage that classifies, corrects one bit and registers data and flags
`timescale 1ns/10ps

module secded_corrector #(
    // Data width carried by the codeword
    parameter int WIDTH = 16
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    // Level enable that holds the outputs while low
    input  logic                                       enable,
    // Received codeword as the checker sees it
    input  logic [secded_pkg::total_width(WIDTH)-1:0] codeword,
    // Checker results for that codeword
    input  logic [secded_pkg::parity_bits(WIDTH)-1:0] syndrome,
    input  logic                                       overall_mismatch,
    // Corrected data one cycle after the sample edge
    output logic [WIDTH-1:0]                           data,
    // Any error seen whether corrected or not
    output logic                                       error_detected,
    // Uncorrectable double error
    output logic                                       double_error_detected,
    // Outcome class of the registered word
    output secded_pkg::err_class_e                     err_class
);

    // ------------------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------------------

    localparam int SYN_W = secded_pkg::parity_bits(WIDTH);
    localparam int CW_W  = secded_pkg::total_width(WIDTH);

    // ------------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------------

    // Any Hamming group failed
    logic                   syn_nonzero;
    // Outcome of the word presented this cycle
    secded_pkg::err_class_e class_next;
    // Flags derived from the class
    logic                   err_next;
    logic                   dbl_next;

    assign syn_nonzero = |syndrome;

    // Decode table
    //   syndrome  mismatch  class
    //   zero      low       none
    //   zero      high      overall parity bit hit
    //   nonzero   high      single error, correctable
    //   nonzero   low       double error
    always_comb begin
        case ({syn_nonzero, overall_mismatch})
            2'b00:   class_next = secded_pkg::ERR_NONE;
            2'b01:   class_next = secded_pkg::ERR_OVERALL_BIT;
            2'b11:   class_next = secded_pkg::ERR_SINGLE_CORRECTED;
            default: class_next = secded_pkg::ERR_DOUBLE;
        endcase
    end

    // Every class but none raises the error flag
    assign err_next = (class_next != secded_pkg::ERR_NONE);
    // Only the even-count case is uncorrectable
    assign dbl_next = (class_next == secded_pkg::ERR_DOUBLE);

    // ------------------------------------------------------------------------
    // Correction mask
    // ------------------------------------------------------------------------

    // One-hot mask of the bit to invert, empty unless single-corrected
    logic [CW_W-1:0] flip_mask;

    // Syndrome names the position and the index is one lower
    // Positions past the Hamming part can only come from 3+ errors
    // and leave the mask empty
    always_comb begin
        flip_mask = '0;
        for (int j = 0; j < CW_W - 1; j++) begin
            flip_mask[j] = (class_next == secded_pkg::ERR_SINGLE_CORRECTED) &&
                           (syndrome == SYN_W'(j + 1));
        end
    end

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // Corrected codeword that the data is picked from
    logic [CW_W-1:0] cw_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cw_q                  <= '0;
            error_detected        <= 1'b0;
            double_error_detected <= 1'b0;
            err_class             <= secded_pkg::ERR_NONE;
        end else if (enable) begin
            // Flip the faulty bit on the way in
            cw_q                  <= codeword ^ flip_mask;
            error_detected        <= err_next;
            double_error_detected <= dbl_next;
            err_class             <= class_next;
        end
    end

    // ------------------------------------------------------------------------
    // Data extraction
    // ------------------------------------------------------------------------

    // Data bits sit at the non power of two positions
    // Pure wiring from the register with no logic after the flops
    for (genvar k = 0; k < WIDTH; k++) begin : g_data
        assign data[k] = cw_q[secded_pkg::data_index(WIDTH, k)];
    end

endmodule : secded_corrector

// File: source/secded_decoder.sv
// SECDED decoder top level to instantiate, one word per cycle with one cycle of latency
`timescale 1ns/10ps

module secded_decoder #(
    // Data width from 4 to 128
    parameter int WIDTH = 16
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    // Level sensitive sample strobe
    input  logic                                       enable,
    // Encoded word with overall parity in the MSB
    input  logic [secded_pkg::total_width(WIDTH)-1:0] codeword,
    // Corrected data
    output logic [WIDTH-1:0]                           data,
    output logic                                       error_detected,
    output logic                                       double_error_detected,
    // Outcome class
    output secded_pkg::err_class_e                     err_class
);

    // Syndrome width from the data width
    localparam int SYN_W = secded_pkg::parity_bits(WIDTH);

    // ------------------------------------------------------------------------
    // Checker to corrector
    // ------------------------------------------------------------------------

    // Combinational check results for the current codeword
    logic [SYN_W-1:0] syndrome;
    logic             overall_mismatch;

    // Stateless parity evaluation
    secded_syndrome_check #(
        .WIDTH (WIDTH)
    ) u_check (
        .codeword         (codeword),
        .syndrome         (syndrome),
        .overall_mismatch (overall_mismatch)
    );

    // Classification, correction and the output register
    // Same codeword goes straight in so it lines up with the check
    secded_corrector #(
        .WIDTH (WIDTH)
    ) u_correct (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .enable                (enable),
        .codeword              (codeword),
        .syndrome              (syndrome),
        .overall_mismatch      (overall_mismatch),
        .data                  (data),
        .error_detected        (error_detected),
        .double_error_detected (double_error_detected),
        .err_class             (err_class)
    );

endmodule : secded_decoder

// File: testbench/tb_secded_decoder.sv
// Directed testbench for the SECDED decoder that encodes words, injects errors and checks results
`timescale 1ns/10ps

module tb_secded_decoder;

    // ------------------------------------------------------------------------
    // Geometry and run limits
    // ------------------------------------------------------------------------

    // 16 data bits need 5 check bits plus the overall parity bit
    localparam int DW = 16;
    localparam int PW = 5;
    localparam int CW = DW + PW + 1;

    // Limit well above the roughly 120 cycles the tests take
    localparam int MAX_CYCLES = 2000;

    localparam int CLEAN_WORDS  = 50;
    localparam int DOUBLE_PAIRS = 30;
    localparam int HOLD_CYCLES  = 4;

    logic                   clk;
    logic                   rst_n;
    logic                   enable;
    logic [CW-1:0]          codeword;
    logic [DW-1:0]          data;
    logic                   error_detected;
    logic                   double_error_detected;
    secded_pkg::err_class_e err_class;

    // Generator state and cycle count for the timeout
    logic [31:0] rng_state;
    int          cycle_count;

    secded_decoder #(
        .WIDTH (DW)
    ) dut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .enable                (enable),
        .codeword              (codeword),
        .data                  (data),
        .error_detected        (error_detected),
        .double_error_detected (double_error_detected),
        .err_class             (err_class)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Failure handling and timeout
    // ------------------------------------------------------------------------

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Advances the generator and returns the new value
    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Random index below limit
    function automatic int random_index(input int limit);
        return int'(next_random() % 32'(limit));
    endfunction

    // Reference encoder
    // Position p sits at index p - 1, check bit i at position 2^i
    // Data fills the other positions in ascending order
    function automatic logic [CW-1:0] encode(input logic [DW-1:0] d);
        logic [CW-1:0] cw;
        logic          par;
        int            k;
        int            pos;
        int            i;
        cw = '0;
        k  = 0;
        for (pos = 1; pos < CW; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                cw[pos-1] = d[k];
                k = k + 1;
            end
        end
        // Check bit i covers the other positions with bit i set
        for (i = 0; i < PW; i++) begin
            par = 1'b0;
            for (pos = 1; pos < CW; pos++) begin
                if ((((pos >> i) & 1) != 0) && (pos != (1 << i))) begin
                    par = par ^ cw[pos-1];
                end
            end
            cw[(1 << i) - 1] = par;
        end
        // Overall parity over everything else
        cw[CW-1] = ^cw[CW-2:0];
        return cw;
    endfunction

    function automatic logic [CW-1:0] flip_bit(input logic [CW-1:0] cw, input int idx);
        return cw ^ (CW'(1) << idx);
    endfunction

    // Presents one word with enable high
    // Returns at the next falling edge, where the result is stable
    task automatic decode_word(input logic [CW-1:0] cw);
        codeword = cw;
        enable   = 1'b1;
        @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic compare_data(input logic [DW-1:0] expected, input logic [DW-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED data: expected 0x%0h, got 0x%0h", expected, actual);
            abort_run("Mismatch on data");
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            abort_run("Mismatch on a flag");
        end
    endtask

    task automatic compare_class(input secded_pkg::err_class_e expected,
                                 input secded_pkg::err_class_e actual);
        if (actual !== expected) begin
            $display("FAILED err_class: expected 0x%0h (%s), got 0x%0h (%s)",
                     expected, expected.name(), actual, actual.name());
            abort_run("Mismatch on err_class");
        end
    endtask

    // All outputs at once with data optional for double errors
    task automatic check_outputs(input logic                   check_data,
                                 input logic [DW-1:0]          exp_data,
                                 input logic                   exp_err,
                                 input logic                   exp_dbl,
                                 input secded_pkg::err_class_e exp_class);
        if (check_data) begin
            compare_data(exp_data, data);
        end
        compare_flag("error_detected", exp_err, error_detected);
        compare_flag("double_error_detected", exp_dbl, double_error_detected);
        compare_class(exp_class, err_class);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    // Outputs cleared during reset and still clear before any enabled cycle
    task automatic reset_clears_outputs;
        repeat (5) begin
            @(negedge clk);
            check_outputs(1'b1, '0, 1'b0, 1'b0, secded_pkg::ERR_NONE);
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_outputs(1'b1, '0, 1'b0, 1'b0, secded_pkg::ERR_NONE);
        end
    endtask

    // Back to back clean words with enable held high
    task automatic clean_words_pass;
        logic [DW-1:0] d;
        for (int n = 0; n < CLEAN_WORDS; n++) begin
            d = DW'(next_random());
            decode_word(encode(d));
            check_outputs(1'b1, d, 1'b0, 1'b0, secded_pkg::ERR_NONE);
        end
        enable = 1'b0;
    endtask

    // Every index of the Hamming part in turn
    task automatic single_errors_corrected;
        logic [DW-1:0] d;
        logic [CW-1:0] cw;
        d  = DW'(next_random());
        cw = encode(d);
        for (int idx = 0; idx < CW - 1; idx++) begin
            decode_word(flip_bit(cw, idx));
            check_outputs(1'b1, d, 1'b1, 1'b0, secded_pkg::ERR_SINGLE_CORRECTED);
        end
        enable = 1'b0;
    endtask

    // Only the overall parity bit is wrong
    task automatic overall_bit_flagged;
        logic [DW-1:0] d;
        d = DW'(next_random());
        decode_word(flip_bit(encode(d), CW - 1));
        check_outputs(1'b1, d, 1'b1, 1'b0, secded_pkg::ERR_OVERALL_BIT);
        enable = 1'b0;
    endtask

    // Two distinct indices with the MSB included in the draw
    task automatic double_errors_flagged;
        logic [DW-1:0] d;
        int            idx_a;
        int            idx_b;
        for (int n = 0; n < DOUBLE_PAIRS; n++) begin
            d     = DW'(next_random());
            idx_a = random_index(CW);
            idx_b = random_index(CW - 1);
            if (idx_b >= idx_a) begin
                idx_b = idx_b + 1;
            end
            decode_word(flip_bit(flip_bit(encode(d), idx_a), idx_b));
            check_outputs(1'b0, '0, 1'b1, 1'b1, secded_pkg::ERR_DOUBLE);
        end
        enable = 1'b0;
    endtask

    // Corrected word first and then a double error held off by enable low
    task automatic enable_low_holds;
        logic [DW-1:0] d;
        logic [DW-1:0] other;
        d     = DW'(next_random());
        other = d ^ (DW'(next_random()) | DW'(1));
        decode_word(flip_bit(encode(d), 3));
        check_outputs(1'b1, d, 1'b1, 1'b0, secded_pkg::ERR_SINGLE_CORRECTED);
        enable   = 1'b0;
        codeword = flip_bit(flip_bit(encode(other), 0), 6);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_outputs(1'b1, d, 1'b1, 1'b0, secded_pkg::ERR_SINGLE_CORRECTED);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        codeword    = '0;
        rng_state   = 32'h56bb_33fb;
        cycle_count = 0;

        reset_clears_outputs();
        clean_words_pass();
        single_errors_corrected();
        overall_bit_flagged();
        double_errors_flagged();
        enable_low_holds();

        $display("TEST OK");
        $finish;
    end

endmodule : tb_secded_decoder

// File: tb.f
common/secded_pkg.sv
decoder/secded_syndrome_check.sv
decoder/secded_corrector.sv
source/secded_decoder.sv
testbench/tb_secded_decoder.sv

// File: Makefile
# Verilator build for the SECDED decoder testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=obj

TOP       ?= tb_secded_decoder
BUILD_DIR ?= build
FILELIST  ?= tb.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Run and decide pass or fail from the printed output
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "TEST OK"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
